// File: run_sim.sh
#!/bin/sh
# build and run the sdram controller testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_sdram_ctrl -f src.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "NO ERRORS"; then
  exit 0
fi
echo "simulation did not report a clean run"
exit 1

// File: source/sdram_cmd_fsm.sv
`timescale 1ns/1ps

// command sequencer
// power-up, then single word accesses with auto-precharge and refresh
// every command state loads the wait timer and parks in st_wait
module sdram_cmd_fsm
  import sdram_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  req_valid,          // host access pending
  input  host_req_t             req,                // held until req_done
  input  logic                  refresh_req,        // level, wins over host access
  input  logic                  wait_done,          // last cycle of current wait
  output logic                  load,               // start the wait timer
  output logic [wait_cnt_w-1:0] load_value,         // wait length
  output sdram_cmd_t            sdram_cmd,          // control pins
  output logic                  dq_oe,              // drive dq
  output logic                  req_done            // access finished, one cycle
);

  typedef enum logic [3:0] {
    st_reset_wait,                                  // cke low for 100 us
    st_init_precharge,                              // precharge all banks
    st_init_refresh1,                               // first power-up refresh
    st_init_refresh2,                               // second power-up refresh
    st_init_load_mode,                              // program the mode register
    st_idle,                                        // wait for refresh or host
    st_activate,                                    // open row
    st_read,                                        // read with auto-precharge
    st_capture,                                     // read word on dq_in
    st_write,                                       // write with auto-precharge
    st_refresh,                                     // refresh on demand
    st_wait                                         // shared wait, exits to ret_q
  } state_e;

  state_e state_q, state_d;
  state_e ret_q, ret_d;                             // where st_wait goes next
  logic   wr_done_q, wr_done_d;                     // write ack owed on return to idle

  logic [row_w-1:0]  row;                           // host address split
  logic [col_w-1:0]  col;
  logic [bank_w-1:0] bank;
  logic [row_w-1:0]  col_addr;                      // column phase address with A10

  assign row  = req.addr[row_lsb +: row_w];         // addr[23:11]
  assign col  = req.addr[col_lsb +: col_w];         // addr[10:2]
  assign bank = req.addr[bank_w-1:0];               // addr[1:0]

  always_comb
  begin
    col_addr = '0;
    col_addr[col_w-1:0] = col;                      // column on addr[8:0]
    col_addr[ap_bit] = 1'b1;                        // auto-precharge after the access
  end

  ////////////////////////////////////////////////////////////////////////////
  // next state and pin decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    state_d        = state_q;                       // defaults, hold and nop
    ret_d          = ret_q;
    wr_done_d      = wr_done_q;
    load           = 1'b0;
    load_value     = '0;
    dq_oe          = 1'b0;
    req_done       = 1'b0;
    sdram_cmd.cke  = 1'b1;
    sdram_cmd.op   = op_nop;
    sdram_cmd.ba   = '0;
    sdram_cmd.addr = '0;

    case (state_q)
      st_reset_wait:
      begin
        sdram_cmd.cke = 1'b0;                       // device clock stays gated
        load_value = init_wait_cycles;
        load = 1'b1;
        ret_d = st_init_precharge;
        state_d = st_wait;
      end
      st_init_precharge:
      begin
        sdram_cmd.op = op_precharge;
        sdram_cmd.addr = all_banks_addr;            // A10 high, all banks
        load_value = trp_cycles;
        load = 1'b1;
        ret_d = st_init_refresh1;
        state_d = st_wait;
      end
      st_init_refresh1:
      begin
        sdram_cmd.op = op_refresh;
        load_value = trfc_cycles;
        load = 1'b1;
        ret_d = st_init_refresh2;
        state_d = st_wait;
      end
      st_init_refresh2:
      begin
        sdram_cmd.op = op_refresh;
        load_value = trfc_cycles;
        load = 1'b1;
        ret_d = st_init_load_mode;
        state_d = st_wait;
      end
      st_init_load_mode:
      begin
        sdram_cmd.op = op_load_mode;
        sdram_cmd.addr = mode_word;                 // bl1, cl2, single write
        load_value = tmrd_cycles;
        load = 1'b1;
        ret_d = st_idle;
        state_d = st_wait;
      end
      st_idle:
      begin
        // a finished write is acked here, req_valid is still high this cycle
        if (wr_done_q)
        begin
          req_done = 1'b1;
          wr_done_d = 1'b0;
        end
        if (refresh_req)
          state_d = st_refresh;                     // refresh first
        else if (req_valid && !wr_done_q)
          state_d = st_activate;
      end
      st_activate:
      begin
        sdram_cmd.op = op_active;
        sdram_cmd.ba = bank;
        sdram_cmd.addr = row;
        load_value = trcd_cycles;
        load = 1'b1;
        ret_d = req.we ? st_write : st_read;
        state_d = st_wait;
      end
      st_read:
      begin
        sdram_cmd.op = op_read;
        sdram_cmd.ba = bank;
        sdram_cmd.addr = col_addr;
        load_value = cas_latency;                   // word shows up in st_capture
        load = 1'b1;
        ret_d = st_capture;
        state_d = st_wait;
      end
      st_capture:
      begin
        req_done = 1'b1;                            // port takes dq_in this cycle
        load_value = trp_cycles;                    // auto-precharge still running
        load = 1'b1;
        ret_d = st_idle;
        state_d = st_wait;
      end
      st_write:
      begin
        sdram_cmd.op = op_write;
        sdram_cmd.ba = bank;
        sdram_cmd.addr = col_addr;
        dq_oe = 1'b1;                               // only cycle that drives dq
        wr_done_d = 1'b1;
        load_value = trp_cycles;                    // write recovery plus precharge
        load = 1'b1;
        ret_d = st_idle;
        state_d = st_wait;
      end
      st_refresh:
      begin
        sdram_cmd.op = op_refresh;
        load_value = trfc_cycles;
        load = 1'b1;
        ret_d = st_idle;
        state_d = st_wait;
      end
      st_wait:
      begin
        if (ret_q == st_init_precharge)
          sdram_cmd.cke = 1'b0;                     // still inside the 100 us
        if (wait_done)
          state_d = ret_q;
      end
      default:
      begin
        state_d = st_reset_wait;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state_q   <= st_reset_wait;                   // restart power-up
      ret_q     <= st_reset_wait;
      wr_done_q <= 1'b0;
    end
    else
    begin
      state_q   <= state_d;
      ret_q     <= ret_d;
      wr_done_q <= wr_done_d;
    end
  end

endmodule

// File: source/sdram_ctrl_top.sv
`timescale 1ns/1ps

// sdram controller for one x16 sdr device
// cs_n and the byte masks are tied on the board, the dq pad buffer
// sits in the board top around dq_out, dq_oe and dq_in
module sdram_ctrl_top
  import sdram_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   wb_cyc,
  input  logic                   wb_stb,
  input  logic                   wb_we,
  input  logic [host_addr_w-1:0] wb_adr,
  input  logic [data_w-1:0]      wb_dat_w,
  output logic [data_w-1:0]      wb_dat_r,
  output logic                   wb_ack,
  input  logic                   refresh_req,       // level, served when idle
  output sdram_cmd_t             sdram_cmd,         // cke, ras/cas/we, ba, addr
  output logic [data_w-1:0]      dq_out,
  output logic                   dq_oe,
  input  logic [data_w-1:0]      dq_in
);

  logic                  req_valid;                 // port to sequencer
  host_req_t             req;
  logic                  req_done;                  // sequencer to port
  logic                  load;                      // sequencer to timer
  logic [wait_cnt_w-1:0] load_value;
  logic                  wait_done;                 // timer to sequencer

  assign dq_out = req.wdata;                        // held by the master until ack

  sdram_wb_port wb_port_inst (
    .clk        (clk),
    .reset      (reset),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .req_valid  (req_valid),
    .req        (req),
    .req_done   (req_done),
    .dq_in      (dq_in)
  );

  sdram_cmd_fsm cmd_fsm_inst (
    .clk         (clk),
    .reset       (reset),
    .req_valid   (req_valid),
    .req         (req),
    .refresh_req (refresh_req),
    .wait_done   (wait_done),
    .load        (load),
    .load_value  (load_value),
    .sdram_cmd   (sdram_cmd),
    .dq_oe       (dq_oe),
    .req_done    (req_done)
  );

  sdram_wait_timer wait_timer_inst (
    .clk        (clk),
    .reset      (reset),
    .load       (load),
    .load_value (load_value),
    .wait_done  (wait_done)
  );

endmodule

// File: source/sdram_pkg.sv
package sdram_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // field widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int row_w       = 13;                  // device row address
  localparam int col_w       = 9;                   // device column address
  localparam int bank_w      = 2;                   // four internal banks
  localparam int data_w      = 16;                  // one x16 device
  localparam int host_addr_w = 24;                  // host word address
  localparam int wait_cnt_w  = 14;                  // wide enough for the 100 us wait

  // host address split
  // row is addr[23:11], column is addr[10:2], bank is addr[1:0]
  // banks sit in the low bits so consecutive words spread over all banks
  localparam int col_lsb = bank_w;                  // column starts above the bank bits
  localparam int row_lsb = bank_w + col_w;          // row starts above the column bits
  localparam int ap_bit  = 10;                      // A10, auto-precharge / all banks

  ////////////////////////////////////////////////////////////////////////////
  // timing, in clk cycles at 25 MHz
  ////////////////////////////////////////////////////////////////////////////

  // every count is at least one, the wait timer treats zero as idle
  localparam logic [wait_cnt_w-1:0] init_wait_cycles = 14'd2500; // 100 us with cke low
  localparam logic [wait_cnt_w-1:0] trp_cycles       = 14'd1;    // precharge period
  localparam logic [wait_cnt_w-1:0] trfc_cycles      = 14'd2;    // auto-refresh period
  localparam logic [wait_cnt_w-1:0] trcd_cycles      = 14'd1;    // activate to column cmd
  localparam logic [wait_cnt_w-1:0] tmrd_cycles      = 14'd2;    // mode register set
  localparam logic [wait_cnt_w-1:0] cas_latency      = 14'd2;    // read latency, also in mode

  ////////////////////////////////////////////////////////////////////////////
  // command encodings
  ////////////////////////////////////////////////////////////////////////////

  // {ras_n, cas_n, we_n} with cs_n tied low on the board
  typedef enum logic [2:0] {
    op_load_mode = 3'b000,                          // mode word on addr
    op_refresh   = 3'b001,                          // auto-refresh while cke is high
    op_precharge = 3'b010,                          // A10 high closes all banks
    op_write     = 3'b100,                          // column cmd, data on dq same cycle
    op_read      = 3'b101,                          // column cmd, data after cas latency
    op_active    = 3'b011,                          // opens a row in bank ba
    op_nop       = 3'b111                           // no operation
  } sdram_op_e;

  // A10 only, used by the power-up precharge
  localparam logic [row_w-1:0] all_banks_addr = 13'h0400;

  // mode register
  // burst length 1, sequential, cas latency in 6:4, standard operation,
  // single location write burst in bit 9
  localparam logic [row_w-1:0] mode_word = {
    3'b000,                                         // reserved
    1'b1,                                           // write burst mode single
    2'b00,                                          // operating mode standard
    cas_latency[2:0],                               // cas latency
    1'b0,                                           // sequential burst
    3'b000                                          // burst length 1
  };

  ////////////////////////////////////////////////////////////////////////////
  // structs
  ////////////////////////////////////////////////////////////////////////////

  // all control pins for one cycle, 19 bits
  typedef struct packed {
    logic                  cke;                     // clock enable
    sdram_op_e             op;                      // ras/cas/we
    logic [bank_w-1:0]     ba;                      // bank select
    logic [row_w-1:0]      addr;                    // row, column or mode word
  } sdram_cmd_t;

  // one pending host access, 41 bits
  typedef struct packed {
    logic                  we;                      // 1 for write
    logic [host_addr_w-1:0] addr;                   // word address
    logic [data_w-1:0]     wdata;                   // write data
  } host_req_t;

endpackage

// File: source/sdram_wait_timer.sv
`timescale 1ns/1ps

// down counter shared by every wait of the sequencer
// a load of n raises wait_done in the nth cycle after the load, for one cycle
module sdram_wait_timer
  import sdram_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  load,               // start a new wait
  input  logic [wait_cnt_w-1:0] load_value,         // length of the wait in cycles
  output logic                  wait_done           // last cycle of the wait
);

  logic [wait_cnt_w-1:0] count_q;                   // cycles left, zero when idle

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      count_q <= '0;                                // nothing running after reset
    end
    else if (load)
    begin
      count_q <= load_value;                        // first wait cycle sees n
    end
    else if (count_q != '0)
    begin
      count_q <= count_q - 1'b1;                    // count down to one, then rest
    end
  end

  // count reads one in the final cycle of the wait
  assign wait_done = (count_q == wait_cnt_w'(1));

endmodule

// File: source/sdram_wb_port.sv
`timescale 1ns/1ps

// wishbone classic slave
// the master holds the request until ack, so the request is packed straight
// from the bus and only the ack and the read word are registered
module sdram_wb_port
  import sdram_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   wb_cyc,            // bus cycle active
  input  logic                   wb_stb,            // transfer strobe
  input  logic                   wb_we,             // 1 for write
  input  logic [host_addr_w-1:0] wb_adr,            // word address
  input  logic [data_w-1:0]      wb_dat_w,          // write data
  output logic [data_w-1:0]      wb_dat_r,          // read data, valid with ack
  output logic                   wb_ack,            // one cycle per transfer
  output logic                   req_valid,         // to sequencer
  output host_req_t              req,               // pending access
  input  logic                   req_done,          // access finished
  input  logic [data_w-1:0]      dq_in              // read word from the pins
);

  ////////////////////////////////////////////////////////////////////////////
  // request towards the sequencer
  ////////////////////////////////////////////////////////////////////////////

  // pending while strobed and not yet acknowledged
  assign req_valid = wb_cyc & wb_stb & ~wb_ack;

  always_comb
  begin
    req.we    = wb_we;
    req.addr  = wb_adr;
    req.wdata = wb_dat_w;                           // also drives dq_out at the top
  end

  ////////////////////////////////////////////////////////////////////////////
  // acknowledge and read data
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wb_ack <= 1'b0;
    end
    else
    begin
      wb_ack <= req_done;                           // one cycle after req_done
    end
  end

  // read word held until the next read completes
  always_ff @(posedge clk)
  begin
    if (req_done && !wb_we)
    begin
      wb_dat_r <= dq_in;
    end
  end

endmodule

// File: src.f
source/sdram_pkg.sv
source/sdram_wait_timer.sv
source/sdram_cmd_fsm.sv
source/sdram_wb_port.sv
source/sdram_ctrl_top.sv
verif/sdram_model.sv
verif/sdram_ctrl_asserts.sv
verif/tb_sdram_ctrl.sv

// File: verif/sdram_ctrl_asserts.sv
`timescale 1ns/1ps

// pin and bus protocol checks, bound into the controller top
module sdram_ctrl_asserts
  import sdram_pkg::*;
(
  input logic       clk,
  input logic       reset,
  input sdram_cmd_t sdram_cmd,                      // control pins
  input logic       dq_oe,
  input logic       wb_ack,
  input logic       load,                           // timer start
  input logic       wait_done                       // timer end
);

  logic busy_q;                                     // wait timer running

  always_ff @(posedge clk)
  begin
    if (reset)
      busy_q <= 1'b0;
    else if (load)
      busy_q <= 1'b1;                               // counting from the next cycle
    else if (wait_done)
      busy_q <= 1'b0;                               // last wait cycle seen
  end

  cke_low_nop: assert property (@(posedge clk) disable iff (reset)
    !sdram_cmd.cke |-> sdram_cmd.op == op_nop)
    else $error("command issued while cke is low");

  dq_oe_write: assert property (@(posedge clk) disable iff (reset)
    dq_oe |-> sdram_cmd.op == op_write)
    else $error("dq driven without a write command");

  ack_one_cycle: assert property (@(posedge clk) disable iff (reset)
    wb_ack |=> !wb_ack)
    else $error("wb_ack held longer than one cycle");

  quiet_in_wait: assert property (@(posedge clk) disable iff (reset)
    busy_q |-> sdram_cmd.op == op_nop)
    else $error("command issued while the wait timer runs");

endmodule

bind sdram_ctrl_top sdram_ctrl_asserts asserts_inst (
  .clk       (clk),
  .reset     (reset),
  .sdram_cmd (sdram_cmd),
  .dq_oe     (dq_oe),
  .wb_ack    (wb_ack),
  .load      (load),
  .wait_done (wait_done)
);

// File: verif/sdram_model.sv
`timescale 1ns/1ps

// behavioral x16 sdr sdram
// decodes the pins on the rising edge and keeps one open row per bank
// a read word reaches dq_in in the cycle after the cas latency edge and
// stays there for one full cycle, where the controller captures it
module sdram_model
  import sdram_pkg::*;
(
  input  logic              clk,
  input  sdram_cmd_t        sdram_cmd,              // control pins from the controller
  input  logic [data_w-1:0] dq_out,                 // write data
  input  logic              dq_oe,                  // write data driven
  output logic [data_w-1:0] dq_in                   // read data
);

  localparam int cl    = int'(cas_latency);
  localparam int key_w = bank_w + row_w + col_w;    // one word per bank/row/column

  logic [data_w-1:0] mem [logic [key_w-1:0]];       // sparse storage
  logic [row_w-1:0]  open_row [0:(1<<bank_w)-1];    // row opened by the last activate
  logic [data_w-1:0] rd_pipe [0:cl];                // read word on its way to dq

  // words never written read back a pattern of the whole location
  function automatic logic [data_w-1:0] fill_word(input logic [key_w-1:0] key);
    return key[data_w-1:0] ^ data_w'(key >> 8) ^ 16'h5a5a;
  endfunction

  assign dq_in = rd_pipe[cl];

  always @(posedge clk)
  begin
    logic [key_w-1:0] key;
    int               i;
    key = {sdram_cmd.ba, open_row[sdram_cmd.ba], sdram_cmd.addr[col_w-1:0]};
    for (i = cl; i > 0; i--)
    begin
      rd_pipe[i] <= rd_pipe[i-1];                   // shift toward dq_in
    end
    rd_pipe[0] <= '0;                               // bus idles low
    if (sdram_cmd.cke)                              // pins ignored while cke is low
    begin
      case (sdram_cmd.op)
        op_active:
        begin
          open_row[sdram_cmd.ba] <= sdram_cmd.addr;
        end
        op_write:
        begin
          if (dq_oe)
            mem[key] = dq_out;                      // data comes with the command
        end
        op_read:
        begin
          rd_pipe[0] <= mem.exists(key) ? mem[key] : fill_word(key);
        end
        default:
        begin
        end
      endcase
    end
  end

endmodule

// File: verif/tb_sdram_ctrl.sv
`timescale 1ns/1ps

module tb_sdram_ctrl
  import sdram_pkg::*;
();

  localparam int ack_timeout     = 40;              // longest access plus a refresh
  localparam int powerup_timeout = 3000;            // 100 us wait plus init commands
  localparam int op_timeout      = 20;

  logic                   clk;
  logic                   reset;
  logic                   wb_cyc;
  logic                   wb_stb;
  logic                   wb_we;
  logic [host_addr_w-1:0] wb_adr;
  logic [data_w-1:0]      wb_dat_w;
  logic [data_w-1:0]      wb_dat_r;
  logic                   wb_ack;
  logic                   refresh_req;
  sdram_cmd_t             sdram_cmd;
  logic [data_w-1:0]      dq_out;
  logic                   dq_oe;
  logic [data_w-1:0]      dq_in;

  logic [data_w-1:0]      shadow [logic [host_addr_w-1:0]]; // last word written per address
  logic [host_addr_w-1:0] written [$];              // addresses safe to read
  sdram_cmd_t             cmd_log [$];              // every non-nop command on the pins
  int                     cke_low_cycles;
  int                     ack_count;
  int                     error_count;
  int                     check_count;
  int                     pass_count;
  int                     fail_count;
  bit                     hung;                     // set once a wait times out

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;                         // 25 MHz
  end

  sdram_ctrl_top sdram_ctrl_top_inst (
    .clk(clk), .reset(reset),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .refresh_req(refresh_req), .sdram_cmd(sdram_cmd),
    .dq_out(dq_out), .dq_oe(dq_oe), .dq_in(dq_in)
  );

  sdram_model sdram_model_inst (
    .clk(clk), .sdram_cmd(sdram_cmd), .dq_out(dq_out), .dq_oe(dq_oe), .dq_in(dq_in)
  );

  ////////////////////////////////////////////////////////////////////////////
  // reference and compare
  ////////////////////////////////////////////////////////////////////////////

  // a read returns the last word written to the same host address
  function automatic logic [data_w-1:0] expected_read(input logic [host_addr_w-1:0] addr);
    if (shadow.exists(addr))
      return shadow[addr];
    return '0;
  endfunction

  always @(negedge clk)                             // bus is stable mid cycle
  begin
    if (!reset && wb_ack)
    begin
      ack_count++;
      if (wb_we)
        shadow[wb_adr] = wb_dat_w;                  // write done in the device
      else
      begin
        check_count++;
        assert (wb_dat_r == expected_read(wb_adr))
        else
        begin
          $display("ERR %0t wb_dat_r exp %h got %h (addr %h)", $time,
                   expected_read(wb_adr), wb_dat_r, wb_adr);
          error_count++;
        end
      end
    end
  end

  always @(negedge clk)                             // pin monitor
  begin
    if (!reset)
    begin
      if (!sdram_cmd.cke)
        cke_low_cycles++;
      if (sdram_cmd.op != op_nop)
        cmd_log.push_back(sdram_cmd);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // bus driver and helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic start_transfer(input logic we, input logic [host_addr_w-1:0] addr,
                                input logic [data_w-1:0] data);
    @(posedge clk);
    #2;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = addr;
    wb_dat_w = data;
  endtask

  task automatic end_transfer();
    @(posedge clk);
    #2;                                             // cycle after the ack
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wait_ack(input int limit);
    int n;
    if (hung)
      return;
    n = 0;
    @(negedge clk);
    while (!wb_ack && n < limit)
    begin
      @(negedge clk);
      n++;
    end
    if (!wb_ack)
    begin
      $display("timeout at %0t: no wb_ack within %0d cycles", $time, limit);
      error_count++;
      hung = 1'b1;
    end
  endtask

  task automatic wait_op(input sdram_op_e op, input int limit);
    int n;
    if (hung)
      return;
    n = 0;
    @(negedge clk);
    while (sdram_cmd.op != op && n < limit)
    begin
      @(negedge clk);
      n++;
    end
    if (sdram_cmd.op != op)
    begin
      $display("timeout at %0t: %s never seen on the pins", $time, op.name());
      error_count++;
      hung = 1'b1;
    end
  endtask

  task automatic run_transfer(input logic we, input logic [host_addr_w-1:0] addr,
                              input logic [data_w-1:0] data);
    start_transfer(we, addr, data);
    wait_ack(ack_timeout);
    end_transfer();
    if (we)
      written.push_back(addr);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
    check_count++;
    assert (got == exp)
    else
    begin
      $display("ERR %0t %s exp %h got %h", $time, name, exp, got);
      error_count++;
    end
  endtask

  // activate then column command with fields from the host address
  task automatic check_mapping(input logic [host_addr_w-1:0] addr, input logic we,
                               input int first);
    sdram_cmd_t act;
    sdram_cmd_t col;
    if (cmd_log.size() < first + 2)
    begin
      $display("missing activate or column command for address %h", addr);
      error_count++;
      return;
    end
    act = cmd_log[first];
    col = cmd_log[first + 1];
    check_value("sdram_cmd.op (activate)", 32'(op_active), 32'(act.op));
    check_value("sdram_cmd.ba (activate)", 32'(addr[1:0]), 32'(act.ba));
    check_value("sdram_cmd.addr (row)", 32'(addr[23:11]), 32'(act.addr));
    check_value("sdram_cmd.op (column)", 32'(we ? op_write : op_read), 32'(col.op));
    check_value("sdram_cmd.ba (column)", 32'(addr[1:0]), 32'(col.ba));
    check_value("sdram_cmd.addr (column)", 32'(addr[10:2]), 32'(col.addr[8:0]));
    check_value("sdram_cmd.addr[10]", 32'(1), 32'(col.addr[10]));
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (error_count == errors_before)
    begin
      pass_count++;
      $display("test %s passed", name);
    end
    else
    begin
      fail_count++;
      $display("test %s failed, %0d errors", name, error_count - errors_before);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test list
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    int                     errs;
    int                     mark;
    int                     acks;
    logic [host_addr_w-1:0] addr;
    logic [data_w-1:0]      data;
    logic [row_w-1:0]       mode_exp;
    void'($urandom(32'hd56b));
    reset = 1'b1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    refresh_req = 1'b0;
    cke_low_cycles = 0;
    ack_count = 0;
    error_count = 0;
    check_count = 0;
    pass_count = 0;
    fail_count = 0;
    hung = 1'b0;
    mode_exp = (row_w'(cas_latency) << 4) | (row_w'(1) << 9); // bl1, seq, single write
    repeat (3) @(posedge clk);
    #2;
    reset = 1'b0;

    // power-up with a write strobed from the start
    errs = error_count;
    addr = host_addr_w'($urandom());
    data = data_w'($urandom());
    start_transfer(1'b1, addr, data);
    wait_ack(powerup_timeout);
    end_transfer();
    written.push_back(addr);
    assert (cke_low_cycles >= int'(init_wait_cycles))
    else
    begin
      $display("cke was low for only %0d cycles", cke_low_cycles);
      error_count++;
    end
    if (cmd_log.size() >= 6)
    begin
      check_value("sdram_cmd.op (1st)", 32'(op_precharge), 32'(cmd_log[0].op));
      check_value("sdram_cmd.addr[10] (1st)", 32'(1), 32'(cmd_log[0].addr[10]));
      check_value("sdram_cmd.op (2nd)", 32'(op_refresh), 32'(cmd_log[1].op));
      check_value("sdram_cmd.op (3rd)", 32'(op_refresh), 32'(cmd_log[2].op));
      check_value("sdram_cmd.op (4th)", 32'(op_load_mode), 32'(cmd_log[3].op));
      check_value("sdram_cmd.addr (mode)", 32'(mode_exp), 32'(cmd_log[3].addr));
      check_mapping(addr, 1'b1, 4);                 // access only after load mode
    end
    else
    begin
      $display("only %0d commands seen by the end of power-up", cmd_log.size());
      error_count++;
    end
    check_value("wb_ack count", 32'(1), 32'(ack_count));
    report_test("power_up", errs);

    // write then read at one address
    errs = error_count;
    addr = host_addr_w'($urandom());
    run_transfer(1'b1, addr, data_w'($urandom()));
    run_transfer(1'b0, addr, '0);
    report_test("write_read", errs);

    // pin fields for one random address
    errs = error_count;
    addr = host_addr_w'($urandom());
    mark = cmd_log.size();
    run_transfer(1'b1, addr, data_w'($urandom()));
    check_mapping(addr, 1'b1, mark);
    mark = cmd_log.size();
    run_transfer(1'b0, addr, '0);
    check_mapping(addr, 1'b0, mark);
    report_test("address_mapping", errs);

    // random writes mixed with reads of written words
    errs = error_count;
    repeat (40)
    begin
      if ($urandom_range(1) == 1)
        run_transfer(1'b1, host_addr_w'($urandom()), data_w'($urandom()));
      else
        run_transfer(1'b0, written[$urandom_range(written.size() - 1)], '0);
    end
    report_test("random_traffic", errs);

    // refresh and strobe raised together in idle
    errs = error_count;
    addr = written[$urandom_range(written.size() - 1)];
    mark = cmd_log.size();
    start_transfer(1'b0, addr, '0);
    refresh_req = 1'b1;
    wait_op(op_refresh, op_timeout);
    @(posedge clk);
    #2;
    refresh_req = 1'b0;                             // one refresh only
    wait_ack(ack_timeout);
    end_transfer();
    check_value("sdram_cmd.op (first)", 32'(op_refresh), 32'(cmd_log[mark].op));
    check_value("sdram_cmd.op (second)", 32'(op_active), 32'(cmd_log[mark + 1].op));
    report_test("refresh_priority", errs);

    // strobe arriving during a refresh followed by back-to-back reads
    errs = error_count;
    acks = ack_count;
    addr = host_addr_w'($urandom());
    @(posedge clk);
    #2;
    refresh_req = 1'b1;
    wait_op(op_refresh, op_timeout);
    start_transfer(1'b1, addr, data_w'($urandom())); // strobe while the refresh runs
    refresh_req = 1'b0;                             // one refresh only
    wait_ack(ack_timeout);
    end_transfer();
    written.push_back(addr);
    run_transfer(1'b0, addr, '0);
    repeat (3)
    begin
      run_transfer(1'b0, written[$urandom_range(written.size() - 1)], '0);
    end
    repeat (6) @(posedge clk);                      // quiet time for a stray ack
    check_value("wb_ack count", 32'(acks + 5), 32'(ack_count));
    report_test("back_pressure", errs);

    $display("tests passed %0d failed %0d, checks %0d, errors %0d",
             pass_count, fail_count, check_count, error_count);
    if (error_count == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule
